// ==== ofs_csr.f ====
logic/fabric_pkg.sv
logic/csr_rst_sync.sv
logic/csr_addr_decode.sv
logic/feature_csr.sv
logic/csr_rd_mux.sv
logic/board_csr_fabric.sv
tb/board_csr_fabric_assertions.sv
tb/tb_board_csr_fabric.sv

// ==== Makefile ====
# Verilator build and run of the CSR fabric testbench

TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_board_csr_fabric
FILELIST   = ofs_csr.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/board_csr_fabric_golden.hex ====
// Columns: opcode, byte address, write data, expected read data
// Opcodes: 1 write, 2 read, 3 read with next op on the following cycle, 4 DFH walk step, 5 PLL drop, 0 end
4 0000 0 300000001000100f
4 1000 0 3000000010000013
4 2000 0 3000000010000013
4 3000 0 3000010000001009
1 0008 0123456789abcdef 0
1 1008 fedcba9876543210 0
1 2008 a5a5a5a55a5a5a5a 0
1 3008 0000cafe00001234 0
1 1000 ffffffffffffffff 0
3 0008 0 0123456789abcdef
3 1008 0 fedcba9876543210
3 2008 0 a5a5a5a55a5a5a5a
2 3008 0 0000cafe00001234
2 1000 0 3000000010000013
2 4000 0 ffffffffffffffff
2 f008 0 ffffffffffffffff
2 0010 0 0000000000000000
5 0000 0 0
3 0008 0 0000000000000000
3 1008 0 0000000000000000
3 2008 0 0000000000000000
2 3008 0 0000000000000000
0 0000 0 0

// ==== tb/tb_board_csr_fabric.sv ====
// CSR fabric testbench
`timescale 1ns/1ps
`default_nettype none

module tb_board_csr_fabric;

   localparam int NUM_FEATURES    = 4;
   localparam int RST_SYNC_STAGES = 3;
   localparam int GOLDEN_OPS      = 32;   // Room for stimulus lines
   localparam int WAIT_LIMIT      = 64;   // Cycles for any single wait
   localparam int READ_LATENCY    = 3;
   localparam int RESET_CYCLES    = 16;

   localparam logic [63:0] OP_END      = 64'd0;
   localparam logic [63:0] OP_WRITE    = 64'd1;
   localparam logic [63:0] OP_READ     = 64'd2;
   localparam logic [63:0] OP_READ_B2B = 64'd3;
   localparam logic [63:0] OP_WALK     = 64'd4;
   localparam logic [63:0] OP_PLL_DROP = 64'd5;

   logic                  clk_csr;
   logic                  arst_n;
   logic                  pll_locked;
   logic                  csr_rd;
   logic                  csr_wr;
   fabric_pkg::csr_addr_t csr_addr;
   fabric_pkg::csr_data_t csr_wdata;
   logic                  csr_rd_valid;
   fabric_pkg::csr_data_t csr_rd_data;
   logic                  rst_ready;

   logic [63:0]           golden_mem [GOLDEN_OPS*4];
   fabric_pkg::csr_data_t exp_q [$];      // Expected data of reads in flight
   int                    issue_q [$];    // Issue cycle of the same reads
   int                    cycle_cnt = 0;
   fabric_pkg::csr_data_t last_rd_data;
   logic [31:0]           rand_state;
   fabric_pkg::csr_addr_t walk_addr;
   logic                  walk_done;

   board_csr_fabric #(
      .NUM_FEATURES    (NUM_FEATURES),
      .RST_SYNC_STAGES (RST_SYNC_STAGES)
   ) UUT (
      .clk_csr      (clk_csr),
      .arst_n       (arst_n),
      .pll_locked   (pll_locked),
      .csr_rd       (csr_rd),
      .csr_wr       (csr_wr),
      .csr_addr     (csr_addr),
      .csr_wdata    (csr_wdata),
      .csr_rd_valid (csr_rd_valid),
      .csr_rd_data  (csr_rd_data),
      .rst_ready    (rst_ready)
   );

   initial clk_csr = 1'b0;
   always #2 clk_csr = ~clk_csr;   // 4 ns period

   always @(posedge clk_csr) cycle_cnt <= cycle_cnt + 1;

   // ************************************************************
   // Failure reporting and helpers
   // ************************************************************
   task automatic abort_run();
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++)
      begin
         @(negedge clk_csr);
         csr_rd = 1'b0;
         csr_wr = 1'b0;
      end
   endtask

   task automatic issue_write(input fabric_pkg::csr_addr_t addr,
                              input fabric_pkg::csr_data_t data);
      @(negedge clk_csr);
      csr_rd    = 1'b0;
      csr_wr    = 1'b1;
      csr_addr  = addr;
      csr_wdata = data;
   endtask

   task automatic issue_read(input fabric_pkg::csr_addr_t addr,
                             input fabric_pkg::csr_data_t exp);
      @(negedge clk_csr);
      csr_rd    = 1'b1;
      csr_wr    = 1'b0;
      csr_addr  = addr;
      csr_wdata = '0;
      exp_q.push_back(exp);
      issue_q.push_back(cycle_cnt);
   endtask

   // Strobes down, then every outstanding read answered
   task automatic drain_reads();
      int n;
      n = 0;
      idle_cycles(1);
      while (exp_q.size() != 0 && n < WAIT_LIMIT)
      begin
         @(posedge clk_csr);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("read responses did not arrive within the wait limit");
         abort_run();
      end
   endtask

   task automatic wait_rst_ready();
      int n;
      n = 0;
      while (rst_ready !== 1'b1 && n < WAIT_LIMIT)
      begin
         @(negedge clk_csr);
         n++;
      end
      if (rst_ready !== 1'b1)
      begin
         $display("rst_ready did not rise after the reset sources were released");
         abort_run();
      end
   endtask

   // Follows the next-offset field of the returned DFH
   task automatic walk_step(input fabric_pkg::csr_addr_t addr,
                            input fabric_pkg::csr_data_t exp);
      if (walk_done)
      begin
         $display("DFH walk went on after the end-of-list bit");
         abort_run();
      end
      check_value("dfh walk address", 64'(walk_addr), 64'(addr));
      issue_read(walk_addr, exp);
      drain_reads();
      if (last_rd_data[40])
         walk_done = 1'b1;
      else
         walk_addr = walk_addr + fabric_pkg::csr_addr_t'(last_rd_data[39:16]);
   endtask

   task automatic drop_pll();
      drain_reads();
      @(negedge clk_csr);
      pll_locked = 1'b0;
      @(negedge clk_csr);
      check_value("rst_ready", 64'(rst_ready), 64'h0);   // Reset asserts at once
      pll_locked = 1'b1;
      wait_rst_ready();
   endtask

   // ************************************************************
   // Response monitor
   // ************************************************************
   always @(negedge clk_csr)
   begin
      if (csr_rd_valid === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("read response arrived with no read outstanding");
            abort_run();
         end
         else
         begin
            check_value("csr_rd_data", csr_rd_data, exp_q.pop_front());
            check_value("read latency", 64'(cycle_cnt - issue_q.pop_front()),
                        64'(READ_LATENCY));
            last_rd_data = csr_rd_data;
         end
      end
   end

   initial
   begin
      int                    op_idx;
      logic                  running;
      logic                  no_gap;
      logic [63:0]           opcode;
      fabric_pkg::csr_addr_t op_addr;
      fabric_pkg::csr_data_t op_wdata;
      fabric_pkg::csr_data_t op_exp;

      arst_n       = 1'b0;
      pll_locked   = 1'b1;
      csr_rd       = 1'b0;
      csr_wr       = 1'b0;
      csr_addr     = '0;
      csr_wdata    = '0;
      rand_state   = 32'hf18b_c51a;
      last_rd_data = '0;
      walk_addr    = '0;
      walk_done    = 1'b0;
      $readmemh("tb/board_csr_fabric_golden.hex", golden_mem);

      // Nothing comes out while reset is held
      for (int i = 0; i < RESET_CYCLES; i++)
      begin
         @(negedge clk_csr);
         check_value("rst_ready", 64'(rst_ready), 64'h0);
         check_value("csr_rd_valid", 64'(csr_rd_valid), 64'h0);
         csr_rd = (i < RESET_CYCLES/2);   // Reads that reset must swallow
      end
      arst_n = 1'b1;
      wait_rst_ready();

      op_idx  = 0;
      running = 1'b1;
      no_gap  = 1'b0;
      while (running && op_idx < GOLDEN_OPS)
      begin
         opcode   = golden_mem[op_idx*4];
         op_addr  = fabric_pkg::csr_addr_t'(golden_mem[op_idx*4+1]);
         op_wdata = golden_mem[op_idx*4+2];
         op_exp   = golden_mem[op_idx*4+3];
         if (!no_gap)
         begin
            rand_state = xorshift32(rand_state);
            idle_cycles(int'(rand_state[1:0]));   // 0 to 3 idle cycles
         end
         no_gap = (opcode == OP_READ_B2B);
         case (opcode)
            OP_WRITE:             issue_write(op_addr, op_wdata);
            OP_READ, OP_READ_B2B: issue_read(op_addr, op_exp);
            OP_WALK:              walk_step(op_addr, op_exp);
            OP_PLL_DROP:          drop_pll();
            OP_END:               running = 1'b0;
            default:
            begin
               $display("unknown opcode in the stimulus file at line %0d", op_idx);
               abort_run();
            end
         endcase
         op_idx++;
      end
      drain_reads();

      if (running || !walk_done)
      begin
         $display("stimulus had no end marker or the DFH walk did not finish");
         abort_run();
      end
      else
      begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb/board_csr_fabric_assertions.sv ====
// CSR fabric protocol checks
`timescale 1ns/1ps
`default_nettype none

module board_csr_fabric_assertions (
   input wire clk_csr,
   input wire rst_ready,
   input wire csr_rd,
   input wire csr_wr,
   input wire csr_rd_valid
);

   localparam int READ_LATENCY = 3;   // Decoder, feature, mux

   // Host strobes are exclusive
   a_rd_wr_exclusive: assert property (@(posedge clk_csr) disable iff (!rst_ready)
      !(csr_rd && csr_wr))
      else $error("csr_rd and csr_wr were high in the same cycle");

   // ************************************************************
   // Read latency in both directions
   // ************************************************************
   a_rd_gets_valid: assert property (@(posedge clk_csr) disable iff (!rst_ready)
      $past(csr_rd, READ_LATENCY) |-> csr_rd_valid)
      else $error("csr_rd_valid missing three cycles after a read");

   a_valid_has_rd: assert property (@(posedge clk_csr) disable iff (!rst_ready)
      csr_rd_valid |-> $past(csr_rd, READ_LATENCY))
      else $error("csr_rd_valid without a read three cycles earlier");

   a_quiet_in_reset: assert property (@(posedge clk_csr) !rst_ready |-> !csr_rd_valid)
      else $error("csr_rd_valid high while rst_ready is low");

endmodule

bind board_csr_fabric board_csr_fabric_assertions protocol_checks (
   .clk_csr      (clk_csr),
   .rst_ready    (rst_ready),
   .csr_rd       (csr_rd),
   .csr_wr       (csr_wr),
   .csr_rd_valid (csr_rd_valid)
);

`default_nettype wire

// ==== logic/board_csr_fabric.sv ====
// Board peripheral CSR fabric
`timescale 1ns/1ps
`default_nettype none

module board_csr_fabric #(
   parameter int NUM_FEATURES    = 4,
   parameter int RST_SYNC_STAGES = 3
) (
   input  wire                         clk_csr,
   input  wire                         arst_n,
   input  wire                         pll_locked,
   input  wire                         csr_rd,
   input  wire                         csr_wr,
   input  wire fabric_pkg::csr_addr_t  csr_addr,
   input  wire fabric_pkg::csr_data_t  csr_wdata,
   output logic                        csr_rd_valid,
   output fabric_pkg::csr_data_t       csr_rd_data,
   output logic                        rst_ready
);

   logic                                       rst_n_csr;
   logic                                       rd_miss;
   fabric_pkg::csr_req_t [NUM_FEATURES-1:0]    feat_req;
   fabric_pkg::csr_rsp_t [NUM_FEATURES-1:0]    feat_rsp;

   // ************************************************************
   // Reset release
   // ************************************************************
   csr_rst_sync #(
      .RST_SYNC_STAGES (RST_SYNC_STAGES)
   ) rst_sync (
      .clk_csr    (clk_csr),
      .arst_n     (arst_n),
      .pll_locked (pll_locked),
      .rst_n_csr  (rst_n_csr)
   );

   assign rst_ready = rst_n_csr;

   // ************************************************************
   // Decode, features, read mux
   // ************************************************************
   csr_addr_decode #(
      .NUM_FEATURES (NUM_FEATURES)
   ) addr_decode (
      .clk_csr   (clk_csr),
      .rst_n_csr (rst_n_csr),
      .csr_rd    (csr_rd),
      .csr_wr    (csr_wr),
      .csr_addr  (csr_addr),
      .csr_wdata (csr_wdata),
      .feat_req  (feat_req),
      .rd_miss   (rd_miss)
   );

   // DFH chain parameters come from the package table
   for (genvar i = 0; i < NUM_FEATURES; i++)
   begin : g_feature
      feature_csr #(
         .FEAT_ID         (fabric_pkg::FEAT_ID_TABLE[i]),
         .FEAT_VER        (fabric_pkg::FEAT_VER_TABLE[i]),
         .NEXT_DFH_OFFSET (fabric_pkg::NEXT_DFH_TABLE[i]),
         .END_OF_LIST     (fabric_pkg::END_OF_LIST_TABLE[i])
      ) feature (
         .clk_csr   (clk_csr),
         .rst_n_csr (rst_n_csr),
         .req       (feat_req[i]),
         .rsp       (feat_rsp[i])
      );
   end

   csr_rd_mux #(
      .NUM_FEATURES (NUM_FEATURES)
   ) rd_mux (
      .clk_csr      (clk_csr),
      .rst_n_csr    (rst_n_csr),
      .feat_rsp     (feat_rsp),
      .rd_miss      (rd_miss),
      .csr_rd_valid (csr_rd_valid),
      .csr_rd_data  (csr_rd_data)
   );

endmodule

`default_nettype wire

// ==== logic/csr_rd_mux.sv ====
// CSR read response mux
`timescale 1ns/1ps
`default_nettype none

module csr_rd_mux #(
   parameter int NUM_FEATURES = 4
) (
   input  wire                                           clk_csr,
   input  wire                                           rst_n_csr,
   input  wire fabric_pkg::csr_rsp_t [NUM_FEATURES-1:0]  feat_rsp,
   input  wire                                           rd_miss,
   output logic                                          csr_rd_valid,
   output fabric_pkg::csr_data_t                         csr_rd_data
);

   logic                  miss_q;     // Miss aligned with the feature stage
   logic                  any_valid;
   fabric_pkg::csr_data_t or_data;

   // At most one feature answers per cycle
   always_comb
   begin
      any_valid = 1'b0;
      or_data   = '0;
      for (int i = 0; i < NUM_FEATURES; i++)
      begin
         if (feat_rsp[i].valid)
         begin
            any_valid = 1'b1;
            or_data   = or_data | feat_rsp[i].data;
         end
      end
   end

   // ************************************************************
   // Host response stage
   // ************************************************************
   always_ff @(posedge clk_csr or negedge rst_n_csr)
   begin
      if (!rst_n_csr)
      begin
         miss_q       <= 1'b0;
         csr_rd_valid <= 1'b0;
      end
      else
      begin
         miss_q       <= rd_miss;
         csr_rd_valid <= any_valid | miss_q;
      end
   end

   always_ff @(posedge clk_csr)
   begin
      if (miss_q)
         csr_rd_data <= fabric_pkg::UNMAPPED_DATA;
      else if (any_valid)
         csr_rd_data <= or_data;
   end

endmodule

`default_nettype wire

// ==== logic/feature_csr.sv ====
// Feature CSR block
`timescale 1ns/1ps
`default_nettype none

module feature_csr #(
   parameter fabric_pkg::feat_id_t    FEAT_ID         = 12'h000,
   parameter fabric_pkg::feat_ver_t   FEAT_VER        = 4'h0,
   parameter fabric_pkg::dfh_offset_t NEXT_DFH_OFFSET = 24'h0,
   parameter logic                    END_OF_LIST     = 1'b0
) (
   input  wire                        clk_csr,
   input  wire                        rst_n_csr,
   input  wire fabric_pkg::csr_req_t  req,
   output fabric_pkg::csr_rsp_t       rsp
);

   // ************************************************************
   // Device feature header
   // ************************************************************
   // Type, reserved, end of list, next offset, version, ID
   localparam fabric_pkg::csr_data_t DFH_WORD = {
      fabric_pkg::DFH_TYPE_FEATURE,
      19'h0,
      END_OF_LIST,
      NEXT_DFH_OFFSET,
      FEAT_VER,
      FEAT_ID
   };

   fabric_pkg::csr_data_t scratch_q;
   logic                  rsp_valid_q;
   fabric_pkg::csr_data_t rsp_data_q;

   // Scratchpad, the only writable register
   always_ff @(posedge clk_csr or negedge rst_n_csr)
   begin
      if (!rst_n_csr)
      begin
         scratch_q <= '0;
      end
      else if (req.wr && req.offset == fabric_pkg::SCRATCH_REG_OFF)
      begin
         scratch_q <= req.wdata;
      end
   end

   always_ff @(posedge clk_csr or negedge rst_n_csr)
   begin
      if (!rst_n_csr)
      begin
         rsp_valid_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= req.rd;   // Writes get no answer
      end
   end

   // ************************************************************
   // Read data
   // ************************************************************
   always_ff @(posedge clk_csr)
   begin
      if (req.rd)
      begin
         case (req.offset)
            fabric_pkg::DFH_REG_OFF:     rsp_data_q <= DFH_WORD;
            fabric_pkg::SCRATCH_REG_OFF: rsp_data_q <= scratch_q;
            default:                     rsp_data_q <= '0;   // Unused offsets
         endcase
      end
   end

   assign rsp = {rsp_valid_q, rsp_data_q};

endmodule

`default_nettype wire

// ==== logic/csr_addr_decode.sv ====
// CSR request decoder
`timescale 1ns/1ps
`default_nettype none

module csr_addr_decode #(
   parameter int NUM_FEATURES = 4
) (
   input  wire                                       clk_csr,
   input  wire                                       rst_n_csr,
   input  wire                                       csr_rd,
   input  wire                                       csr_wr,
   input  wire fabric_pkg::csr_addr_t                csr_addr,
   input  wire fabric_pkg::csr_data_t                csr_wdata,
   output fabric_pkg::csr_req_t [NUM_FEATURES-1:0]   feat_req,
   output logic                                      rd_miss
);

   localparam int SEL_BITS = $clog2(fabric_pkg::MAX_FEATURES);

   logic [SEL_BITS-1:0]     feat_sel;
   fabric_pkg::reg_off_t    reg_off;
   logic [NUM_FEATURES-1:0] sel_oh;       // One-hot feature select
   logic                    hit;
   logic [NUM_FEATURES-1:0] rd_q;
   logic [NUM_FEATURES-1:0] wr_q;
   fabric_pkg::reg_off_t    off_q;
   fabric_pkg::csr_data_t   wdata_q;

   // Feature number above the offset field
   assign feat_sel = csr_addr[fabric_pkg::FEATURE_ADDR_BITS +: SEL_BITS];
   assign reg_off  = csr_addr[fabric_pkg::FEATURE_ADDR_BITS-1:0];

   always_comb
   begin
      for (int i = 0; i < NUM_FEATURES; i++)
      begin
         sel_oh[i] = (feat_sel == SEL_BITS'(i));
      end
   end

   assign hit = |sel_oh;   // Low when no block sits behind the number

   // ************************************************************
   // Request stage
   // ************************************************************
   always_ff @(posedge clk_csr or negedge rst_n_csr)
   begin
      if (!rst_n_csr)
      begin
         rd_q    <= '0;
         wr_q    <= '0;
         rd_miss <= 1'b0;
      end
      else
      begin
         rd_q    <= {NUM_FEATURES{csr_rd}} & sel_oh;
         wr_q    <= {NUM_FEATURES{csr_wr}} & sel_oh;   // Unmapped writes fall away here
         rd_miss <= csr_rd & ~hit;
      end
   end

   always_ff @(posedge clk_csr)
   begin
      if (csr_rd | csr_wr)
      begin
         off_q   <= reg_off;
         wdata_q <= csr_wdata;
      end
   end

   // Offset and data go to every feature, strobes only to the selected one
   always_comb
   begin
      for (int i = 0; i < NUM_FEATURES; i++)
      begin
         feat_req[i].rd     = rd_q[i];
         feat_req[i].wr     = wr_q[i];
         feat_req[i].offset = off_q;
         feat_req[i].wdata  = wdata_q;
      end
   end

endmodule

`default_nettype wire

// ==== logic/csr_rst_sync.sv ====
// CSR reset release
`timescale 1ns/1ps
`default_nettype none

module csr_rst_sync #(
   parameter int RST_SYNC_STAGES = 3
) (
   input  wire  clk_csr,
   input  wire  arst_n,       // Board reset
   input  wire  pll_locked,
   output logic rst_n_csr
);

   logic                       clr_n;
   logic [RST_SYNC_STAGES-1:0] sync_q;

   // Either source pulls the whole chain low at once
   assign clr_n = arst_n & pll_locked;

   // ************************************************************
   // Release chain, ones shift in after both sources are good
   // ************************************************************
   always_ff @(posedge clk_csr or negedge clr_n)
   begin
      if (!clr_n)
      begin
         sync_q <= '0;
      end
      else
      begin
         sync_q <= {sync_q[RST_SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign rst_n_csr = sync_q[RST_SYNC_STAGES-1];   // Last stage

endmodule

`default_nettype wire

// ==== logic/fabric_pkg.sv ====
// CSR fabric shared definitions
`default_nettype none

package fabric_pkg;

   // ************************************************************
   // Address and data widths
   // ************************************************************
   localparam int FEATURE_ADDR_BITS = 12;   // Offset width inside one feature
   localparam int MAX_FEATURES      = 16;   // Reach of the feature-select field

   typedef logic [15:0]                  csr_addr_t;   // Host byte address
   typedef logic [63:0]                  csr_data_t;
   typedef logic [11:0]                  feat_id_t;
   typedef logic [3:0]                   feat_ver_t;
   typedef logic [23:0]                  dfh_offset_t; // Byte distance to next DFH
   typedef logic [FEATURE_ADDR_BITS-1:0] reg_off_t;

   // Register map inside a feature
   localparam reg_off_t DFH_REG_OFF     = 12'h000;
   localparam reg_off_t SCRATCH_REG_OFF = 12'h008;

   localparam logic [3:0] DFH_TYPE_FEATURE = 4'h3;
   localparam csr_data_t  UNMAPPED_DATA    = '1;   // Reads that hit no feature

   // ************************************************************
   // Request and response seen by one feature
   // ************************************************************
   typedef struct packed {
      logic      rd;
      logic      wr;
      reg_off_t  offset;
      csr_data_t wdata;
   } csr_req_t;

   typedef struct packed {
      logic      valid;
      csr_data_t data;
   } csr_rsp_t;

   // Feature table, indexed by feature number
   localparam feat_id_t    FEAT_ID_TABLE     [4] = '{12'h00f, 12'h013, 12'h013, 12'h009};
   localparam feat_ver_t   FEAT_VER_TABLE    [4] = '{4'h1, 4'h0, 4'h0, 4'h1};
   localparam dfh_offset_t NEXT_DFH_TABLE    [4] = '{24'h1000, 24'h1000, 24'h1000, 24'h0};
   localparam logic        END_OF_LIST_TABLE [4] = '{1'b0, 1'b0, 1'b0, 1'b1};

endpackage

`default_nettype wire
